// File: tb.f
common/uart_pkg.sv
common/wb_pkg.sv
design/uart/uart_core.sv
design/uart/uart_fifo.sv
design/wb_uart_regs.sv
design/wb_uart.sv
testbench/wb_uart_properties.sv
testbench/tb_wb_uart.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, passing only on the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_wb_uart \
    -f tb.f -o sim_tb_wb_uart \
    && ./obj_dir/sim_tb_wb_uart | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/tb_wb_uart.sv
`timescale 1ns/10ps

module tb_wb_uart
    import uart_pkg::*;
    import wb_pkg::*;
();

    localparam int BIT_CYCLES = BIT_DIVIDER + 2;
    localparam int N_RX       = 10;
    localparam int N_TX       = 12;
    localparam int POLL_LIMIT = 500;
    // loopback, external receive, transmit line and overrun frames
    localparam int N_FRAMES   = FIFO_DEPTH + N_RX + N_TX + FIFO_DEPTH + 3;
    // ten bit times per frame plus the preamble, doubled for idle gaps and bus polling
    localparam int CYCLE_LIMIT = 2 * (N_FRAMES * 10 + int'(TX_IDLE_BITS)) * BIT_CYCLES + 2000;

    logic    clk;
    logic    reset_i;
    logic    rx_i;
    logic    tx_o;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    int seed        = 38907;
    int error_count = 0;
    int check_count = 0;
    int cycles      = 0;

    // reference model: bytes expected on tx_o, DATA words expected on reads, sticky flag
    logic [7:0]  tx_exp [$];
    logic [31:0] rx_exp [$];
    logic        sticky_frame;

    wb_uart dut_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .rx_i     (rx_i),
        .tx_o     (tx_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the tests did not complete", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // DATA read layout, byte in 7:0 and frame error in bit 8
    function automatic logic [31:0] data_word(input logic frame_err, input logic [7:0] data);
        return {23'd0, frame_err, data};
    endfunction

    function automatic logic [31:0] expected_status(input logic rx_empty, input logic tx_full,
                                                    input logic tx_idle, input logic overrun,
                                                    input logic frame_err);
        logic [31:0] word;
        word               = '0;
        word[ST_RX_EMPTY]  = rx_empty;
        word[ST_TX_FULL]   = tx_full;
        word[ST_TX_IDLE]   = tx_idle;
        word[ST_OVERRUN]   = overrun;
        word[ST_FRAME_ERR] = frame_err;
        return word;
    endfunction

    // one classic cycle, request held until ack and dropped right after it
    task automatic bus_access(input logic write_en, input logic [1:0] word,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int   waited;
        logic acked;
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = write_en;
        wb_req.adr = {word, 2'b00};
        wb_req.dat = wdata;
        wb_req.sel = 4'hf;
        waited = 0;
        acked  = 1'b0;
        while (!acked && waited < 8) begin
            @(negedge clk);
            acked = (wb_rsp.ack === 1'b1);
            waited++;
        end
        rdata = wb_rsp.dat;
        assert (acked) else begin
            error_count++;
            $display("no ack on the bus access to register word %0d", word);
        end
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] word, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_access(1'b1, word, wdata, unused);
    endtask

    task automatic wb_read(input logic [1:0] word, output logic [31:0] rdata);
        bus_access(1'b0, word, 32'd0, rdata);
    endtask

    // poll STATUS until one bit reaches the wanted value
    task automatic wait_status(input int bit_pos, input logic value, input string what);
        logic [31:0] status;
        int          polls;
        polls = 0;
        wb_read(REG_STATUS, status);
        while (status[bit_pos] !== value && polls < POLL_LIMIT) begin
            wb_read(REG_STATUS, status);
            polls++;
        end
        assert (status[bit_pos] === value) else begin
            error_count++;
            $display("status never showed %s", what);
        end
    endtask

    // read DATA until the receive FIFO reports empty, each word against the model
    task automatic drain_rx();
        logic [31:0] status;
        logic [31:0] word;
        int          reads;
        reads = 0;
        wb_read(REG_STATUS, status);
        while (!status[ST_RX_EMPTY] && reads <= FIFO_DEPTH) begin
            wb_read(REG_DATA, word);
            assert (rx_exp.size() != 0) else begin
                error_count++;
                $display("DATA returned an entry that was never received");
            end
            if (rx_exp.size() != 0) begin
                check_value("DATA", word, rx_exp.pop_front());
            end
            wb_read(REG_STATUS, status);
            reads++;
        end
        check_value("entries left in the model", rx_exp.size(), 0);
    endtask

    // start bit, eight data bits lsb first, stop bit, then two idle bit times
    task automatic send_frame(input logic [7:0] data, input logic bad_stop);
        logic [9:0] bits;
        bits = {!bad_stop, data, 1'b0};
        @(posedge clk);
        #1;
        for (int i = 0; i < 10; i++) begin
            rx_i = bits[i];
            repeat (BIT_CYCLES) @(posedge clk);
            #1;
        end
        rx_i = 1'b1;
        repeat (2 * BIT_CYCLES) @(posedge clk);
    endtask

    // decode every frame on tx_o at bit centres, sampled on the falling clock edge
    initial begin : tx_monitor
        logic [7:0] frame;
        wait (reset_i == 1'b0);
        forever begin
            @(negedge clk);
            if (tx_o === 1'b0) begin
                repeat (BIT_CYCLES / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CYCLES) @(negedge clk);
                    frame[i] = tx_o;
                end
                repeat (BIT_CYCLES) @(negedge clk);
                check_value("tx_o stop bit", {31'd0, tx_o}, 32'd1);
                assert (tx_exp.size() != 0) else begin
                    error_count++;
                    $display("a frame appeared on tx_o with no byte written");
                end
                if (tx_exp.size() != 0) begin
                    check_value("tx_o frame", {24'd0, frame}, {24'd0, tx_exp.pop_front()});
                end
            end
        end
    end

    initial begin : main
        logic [31:0] word;
        logic [7:0]  data;
        logic        bad;
        int          count;
        int          gap;
        int          total;
        reset_i      = 1'b1;
        rx_i         = 1'b1;
        wb_req       = '0;
        sticky_frame = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset_i = 1'b0;

        // reset state, the preamble keeps the transmitter busy at first
        wb_read(REG_STATUS, word);
        check_value("STATUS after reset", word, expected_status(1, 0, 0, 0, 0));
        check_value("tx_o after reset", {31'd0, tx_o}, 32'd1);
        wait_status(ST_TX_IDLE, 1'b1, "tx idle after the preamble");
        wb_read(REG_STATUS, word);
        check_value("STATUS after preamble", word, expected_status(1, 0, 1, 0, 0));

        // loopback, every byte comes back on the receiver and shows on tx_o
        wb_write(REG_CTRL, 32'd1 << CTRL_LOOPBACK);
        wb_read(REG_CTRL, word);
        check_value("CTRL", word, 32'd1 << CTRL_LOOPBACK);
        count = 1 + ($random(seed) & (FIFO_DEPTH - 1));
        for (int k = 0; k < count; k++) begin
            data = 8'($random(seed));
            wb_write(REG_DATA, {24'd0, data});
            tx_exp.push_back(data);
            rx_exp.push_back(data_word(1'b0, data));
        end
        wait_status(ST_TX_IDLE, 1'b1, "tx idle after the loopback bytes");
        drain_rx();
        check_value("tx frames left after loopback", tx_exp.size(), 0);
        wb_write(REG_CTRL, 32'd0);

        // external receive with occasional low stop bits
        for (int k = 0; k < N_RX; k++) begin
            data = 8'($random(seed));
            bad  = (k == 2) || (($random(seed) & 3) == 0);
            send_frame(data, bad);
            sticky_frame = sticky_frame | bad;
            rx_exp.push_back(data_word(bad, data));
            drain_rx();
            wb_read(REG_STATUS, word);
            check_value("STATUS after receive", word, expected_status(1, 0, 1, 0, sticky_frame));
            if (k == N_RX / 2 - 1 || k == N_RX - 1) begin
                wb_write(REG_STATUS, 32'd1 << ST_FRAME_ERR);
                sticky_frame = 1'b0;
                wb_read(REG_STATUS, word);
                check_value("STATUS after clear", word, expected_status(1, 0, 1, 0, 0));
            end
        end

        // transmit line with random gaps, a write only goes in when there is room
        for (int k = 0; k < N_TX; k++) begin
            data = 8'($random(seed));
            gap  = $random(seed) & 31;
            repeat (gap) @(posedge clk);
            wait_status(ST_TX_FULL, 1'b0, "room in the transmit FIFO");
            wb_write(REG_DATA, {24'd0, data});
            tx_exp.push_back(data);
        end
        wait_status(ST_TX_IDLE, 1'b1, "tx idle after the transmit bytes");
        check_value("tx frames left after transmit", tx_exp.size(), 0);

        // overrun, only the first FIFO_DEPTH frames fit
        for (int k = 0; k < FIFO_DEPTH + 3; k++) begin
            data = 8'($random(seed));
            send_frame(data, 1'b0);
            if (k < FIFO_DEPTH) begin
                rx_exp.push_back(data_word(1'b0, data));
            end
        end
        wb_read(REG_STATUS, word);
        check_value("STATUS after overrun", word, expected_status(0, 0, 1, 1, 0));
        drain_rx();
        wb_write(REG_STATUS, 32'd1 << ST_OVERRUN);
        wb_read(REG_STATUS, word);
        check_value("STATUS after overrun clear", word, expected_status(1, 0, 1, 0, 0));
        wb_read(REG_DATA, word);
        check_value("DATA when empty", word, 32'd0);

        total = error_count + int'(dut_i.props_i.failures);
        $display("checks %0d, errors %0d, property failures %0d",
                 check_count, error_count, dut_i.props_i.failures);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: testbench/wb_uart_properties.sv
`timescale 1ns/10ps

module wb_uart_properties
    import wb_pkg::*;
(
    input logic    clk,
    input logic    reset_i,
    input wb_req_t wb_req_i,
    input wb_rsp_t wb_rsp_i,
    input logic    tx_push_i,
    input logic    tx_pop_i,
    input logic    tx_empty_i,
    input logic    tx_full_i,
    input logic    rx_push_i,
    input logic    rx_pop_i,
    input logic    rx_empty_i,
    input logic    rx_full_i
);

    // the testbench adds this count to its own error total at the end of the run
    int unsigned failures = 0;

    // a classic slave acks once per access and then drops ack
    ack_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else begin
            failures++;
            $error("ack stayed high for two cycles");
        end

    // ack only ever answers a strobe seen in the previous cycle
    ack_after_strobe: assert property (@(posedge clk) disable iff (reset_i)
        wb_rsp_i.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
        else begin
            failures++;
            $error("ack without cyc and stb in the previous cycle");
        end

    // the register block is the only guard against FIFO overflow and underflow
    tx_push_not_full: assert property (@(posedge clk) disable iff (reset_i)
        tx_push_i |-> !tx_full_i)
        else begin
            failures++;
            $error("transmit FIFO pushed while full");
        end

    rx_push_not_full: assert property (@(posedge clk) disable iff (reset_i)
        rx_push_i |-> !rx_full_i)
        else begin
            failures++;
            $error("receive FIFO pushed while full");
        end

    tx_pop_not_empty: assert property (@(posedge clk) disable iff (reset_i)
        tx_pop_i |-> !tx_empty_i)
        else begin
            failures++;
            $error("transmit FIFO popped while empty");
        end

    rx_pop_not_empty: assert property (@(posedge clk) disable iff (reset_i)
        rx_pop_i |-> !rx_empty_i)
        else begin
            failures++;
            $error("receive FIFO popped while empty");
        end

endmodule

bind wb_uart wb_uart_properties props_i (
    .clk        (clk),
    .reset_i    (reset_i),
    .wb_req_i   (wb_req_i),
    .wb_rsp_i   (wb_rsp_o),
    .tx_push_i  (tx_push),
    .tx_pop_i   (tx_pop),
    .tx_empty_i (tx_empty),
    .tx_full_i  (tx_full),
    .rx_push_i  (rx_push),
    .rx_pop_i   (rx_pop),
    .rx_empty_i (rx_empty),
    .rx_full_i  (rx_full)
);

// File: design/wb_uart.sv
`timescale 1ns/10ps

module wb_uart
    import uart_pkg::*;
    import wb_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,

    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o,

    input  logic    rx_i,
    output logic    tx_o
);

    // transmit FIFO side
    logic       tx_push;
    logic [7:0] tx_push_data;
    logic [7:0] tx_head;
    logic       tx_pop;
    logic       tx_empty;
    logic       tx_full;

    // receive FIFO side
    logic       rx_push;
    rx_entry_t  rx_push_data;
    rx_entry_t  rx_head;
    logic       rx_pop;
    logic       rx_empty;
    logic       rx_full;

    // core handshake and serial lines
    logic       core_wr;
    logic [7:0] core_tx_data;
    logic       core_rd;
    logic       core_busy;
    logic       core_rx_valid;
    rx_entry_t  core_rx_entry;
    logic       core_tx;
    logic       core_rx;
    logic       loopback;

    // in loopback the receiver listens to our own transmitter, the pin still shows it
    assign core_rx = loopback ? core_tx : rx_i;
    assign tx_o    = core_tx;

    uart_core core_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .tx_o       (core_tx),
        .rx_i       (core_rx),
        .tx_wr_i    (core_wr),
        .tx_data_i  (core_tx_data),
        .rx_rd_i    (core_rd),
        .rx_entry_o (core_rx_entry),
        .busy_o     (core_busy),
        .rx_valid_o (core_rx_valid)
    );

    uart_fifo #(.payload_t(logic [7:0])) tx_fifo_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (tx_push),
        .push_data_i (tx_push_data),
        .pop_i       (tx_pop),
        .head_o      (tx_head),
        .empty_o     (tx_empty),
        .full_o      (tx_full)
    );

    uart_fifo #(.payload_t(rx_entry_t)) rx_fifo_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (rx_push),
        .push_data_i (rx_push_data),
        .pop_i       (rx_pop),
        .head_o      (rx_head),
        .empty_o     (rx_empty),
        .full_o      (rx_full)
    );

    wb_uart_regs regs_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .wb_req_i        (wb_req_i),
        .wb_rsp_o        (wb_rsp_o),
        .tx_push_o       (tx_push),
        .tx_push_data_o  (tx_push_data),
        .tx_head_i       (tx_head),
        .tx_empty_i      (tx_empty),
        .tx_full_i       (tx_full),
        .tx_pop_o        (tx_pop),
        .core_busy_i     (core_busy),
        .core_wr_o       (core_wr),
        .core_tx_data_o  (core_tx_data),
        .core_rx_valid_i (core_rx_valid),
        .core_rx_entry_i (core_rx_entry),
        .core_rd_o       (core_rd),
        .rx_push_o       (rx_push),
        .rx_push_data_o  (rx_push_data),
        .rx_head_i       (rx_head),
        .rx_empty_i      (rx_empty),
        .rx_full_i       (rx_full),
        .rx_pop_o        (rx_pop),
        .loopback_o      (loopback)
    );

endmodule

// File: design/wb_uart_regs.sv
`timescale 1ns/10ps

module wb_uart_regs
    import uart_pkg::*;
    import wb_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,

    input  wb_req_t    wb_req_i,
    output wb_rsp_t    wb_rsp_o,

    output logic       tx_push_o,
    output logic [7:0] tx_push_data_o,
    input  logic [7:0] tx_head_i,
    input  logic       tx_empty_i,
    input  logic       tx_full_i,
    output logic       tx_pop_o,

    input  logic       core_busy_i,
    output logic       core_wr_o,
    output logic [7:0] core_tx_data_o,
    input  logic       core_rx_valid_i,
    input  rx_entry_t  core_rx_entry_i,
    output logic       core_rd_o,

    output logic       rx_push_o,
    output rx_entry_t  rx_push_data_o,
    input  rx_entry_t  rx_head_i,
    input  logic       rx_empty_i,
    input  logic       rx_full_i,
    output logic       rx_pop_o,

    output logic       loopback_o
);

    logic        ack;
    logic        wr_access;
    logic        rd_access;
    logic [1:0]  word_sel;
    logic [31:0] status_word;
    logic [31:0] rd_data;

    // control register and sticky error flags
    logic        loopback;
    logic        overrun;
    logic        frame_err_seen;

    // ack follows a fresh strobe by one cycle and never lasts two
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack <= 1'b0;
        end else begin
            ack <= wb_req_i.cyc && wb_req_i.stb && !ack;
        end
    end

    // every side effect is tied to the ack cycle
    assign word_sel  = wb_req_i.adr[3:2];
    assign wr_access = ack && wb_req_i.cyc && wb_req_i.stb && wb_req_i.we;
    assign rd_access = ack && wb_req_i.cyc && wb_req_i.stb && !wb_req_i.we;

    // a byte written to a full transmit FIFO is dropped
    assign tx_push_o      = wr_access && (word_sel == REG_DATA) && !tx_full_i;
    assign tx_push_data_o = wb_req_i.dat[7:0];

    // hand the head byte to the core as soon as the transmitter is free
    assign core_wr_o      = !tx_empty_i && !core_busy_i;
    assign tx_pop_o       = core_wr_o;
    assign core_tx_data_o = tx_head_i;

    // the core entry is always taken, it only reaches the FIFO if there is room
    assign core_rd_o      = core_rx_valid_i;
    assign rx_push_o      = core_rx_valid_i && !rx_full_i;
    assign rx_push_data_o = core_rx_entry_i;

    // a DATA read of an empty FIFO returns zero and leaves the pointers alone
    assign rx_pop_o = rd_access && (word_sel == REG_DATA) && !rx_empty_i;

    assign loopback_o = loopback;

    always_comb begin
        status_word               = '0;
        status_word[ST_RX_EMPTY]  = rx_empty_i;
        status_word[ST_TX_FULL]   = tx_full_i;
        // idle means nothing queued and nothing on the wire
        status_word[ST_TX_IDLE]   = tx_empty_i && !core_busy_i;
        status_word[ST_OVERRUN]   = overrun;
        status_word[ST_FRAME_ERR] = frame_err_seen;
    end

    always_comb begin
        case (word_sel)
            REG_DATA:   rd_data = rx_empty_i ? 32'd0 : {23'd0, rx_head_i};
            REG_STATUS: rd_data = status_word;
            REG_CTRL:   rd_data = {31'd0, loopback};
            default:    rd_data = 32'd0;
        endcase
    end

    assign wb_rsp_o.ack = ack;
    assign wb_rsp_o.dat = rd_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            loopback <= 1'b0;
        end else if (wr_access && word_sel == REG_CTRL) begin
            loopback <= wb_req_i.dat[CTRL_LOOPBACK];
        end
    end

    // setting wins over a clear that lands in the same cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            overrun        <= 1'b0;
            frame_err_seen <= 1'b0;
        end else begin
            if (wr_access && word_sel == REG_STATUS) begin
                if (wb_req_i.dat[ST_OVERRUN]) begin
                    overrun <= 1'b0;
                end
                if (wb_req_i.dat[ST_FRAME_ERR]) begin
                    frame_err_seen <= 1'b0;
                end
            end
            if (core_rx_valid_i && rx_full_i) begin
                overrun <= 1'b1;
            end
            // only entries that make it into the FIFO count as seen
            if (rx_push_o && core_rx_entry_i.frame_err) begin
                frame_err_seen <= 1'b1;
            end
        end
    end

endmodule

// File: design/uart/uart_fifo.sv
`timescale 1ns/10ps

module uart_fifo
    import uart_pkg::*;
#(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset_i,

    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t head_o,

    output logic     empty_o,
    output logic     full_o
);

    // storage, read through the read pointer without a register stage
    payload_t mem [FIFO_DEPTH];

    // pointers carry one wrap bit above the index
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;

    // same index, the wrap bit tells full from empty
    logic same_index;

    assign same_index = wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0];
    assign empty_o    = same_index && (wr_ptr[FIFO_AW] == rd_ptr[FIFO_AW]);
    assign full_o     = same_index && (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]);

    // the head is the entry under the read pointer, valid only while not empty
    assign head_o = mem[rd_ptr[FIFO_AW-1:0]];

    // the caller never pushes when full or pops when empty
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
        end else if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_ptr <= '0;
        end else if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// File: design/uart/uart_core.sv
`timescale 1ns/10ps

module uart_core
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,

    output logic       tx_o,
    input  logic       rx_i,

    input  logic       tx_wr_i,
    input  logic [7:0] tx_data_i,
    input  logic       rx_rd_i,
    output rx_entry_t  rx_entry_o,

    output logic       busy_o,
    output logic       rx_valid_o
);

    // receiver state, bit timer and shift register
    logic [3:0]       rx_state;
    logic [DIV_W-1:0] rx_divcnt;
    logic [7:0]       rx_shift;
    rx_entry_t        rx_entry;
    logic             rx_valid;

    // transmitter pattern, remaining bit count and bit timer
    logic [9:0]       tx_pattern;
    logic [3:0]       tx_bitcnt;
    logic [DIV_W-1:0] tx_divcnt;
    logic             tx_preamble;

    assign rx_entry_o = rx_entry;
    assign rx_valid_o = rx_valid;
    assign tx_o       = tx_pattern[0];

    // busy covers the pending preamble as well as any frame being shifted out
    assign busy_o = (tx_bitcnt != 4'd0) || tx_preamble;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_state  <= RX_IDLE;
            rx_divcnt <= '0;
            rx_valid  <= 1'b0;
        end else begin
            // the consumer acknowledges the entry, a new stop sample below still wins
            if (rx_rd_i) begin
                rx_valid <= 1'b0;
            end
            case (rx_state)
                RX_IDLE: begin
                    // the timer starts from zero at the falling edge of the start bit
                    rx_divcnt <= '0;
                    if (!rx_i) begin
                        rx_state <= RX_START;
                    end
                end
                RX_START: begin
                    rx_divcnt <= rx_divcnt + 1'b1;
                    if (rx_divcnt > DIV_W'(BIT_DIVIDER / 2)) begin
                        rx_divcnt <= '0;
                        // a line that is high again at mid start bit was only a glitch
                        if (rx_i) begin
                            rx_state <= RX_IDLE;
                        end else begin
                            rx_state <= RX_FIRST_BIT;
                        end
                    end
                end
                RX_STOP: begin
                    rx_divcnt <= rx_divcnt + 1'b1;
                    if (rx_divcnt > DIV_W'(BIT_DIVIDER)) begin
                        // a low stop bit still delivers the byte, but flagged
                        rx_entry.data      <= rx_shift;
                        rx_entry.frame_err <= !rx_i;
                        rx_valid           <= 1'b1;
                        rx_divcnt          <= '0;
                        rx_state           <= RX_IDLE;
                    end
                end
                default: begin
                    rx_divcnt <= rx_divcnt + 1'b1;
                    if (rx_divcnt > DIV_W'(BIT_DIVIDER)) begin
                        // data arrives lsb first so shift in from the top
                        rx_shift  <= {rx_i, rx_shift[7:1]};
                        rx_divcnt <= '0;
                        rx_state  <= rx_state + 4'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tx_pattern  <= '1;
            tx_bitcnt   <= 4'd0;
            tx_divcnt   <= '0;
            tx_preamble <= 1'b1;
        end else if (tx_preamble && tx_bitcnt == 4'd0) begin
            // hold the line idle for a while so the far end can resync
            tx_pattern  <= '1;
            tx_bitcnt   <= TX_IDLE_BITS;
            tx_divcnt   <= '0;
            tx_preamble <= 1'b0;
        end else if (tx_wr_i && tx_bitcnt == 4'd0) begin
            // stop bit, eight data bits, start bit in bit 0
            tx_pattern <= {1'b1, tx_data_i, 1'b0};
            tx_bitcnt  <= TX_FRAME_BITS;
            tx_divcnt  <= '0;
        end else if (tx_bitcnt != 4'd0) begin
            tx_divcnt <= tx_divcnt + 1'b1;
            if (tx_divcnt > DIV_W'(BIT_DIVIDER)) begin
                // ones shift in behind the frame so the line idles high afterwards
                tx_pattern <= {1'b1, tx_pattern[9:1]};
                tx_bitcnt  <= tx_bitcnt - 4'd1;
                tx_divcnt  <= '0;
            end
        end
    end

endmodule

// File: common/wb_pkg.sv
package wb_pkg;

    // classic Wishbone request as seen by the slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        // byte address, bits 3:2 pick the register word
        logic [3:0]  adr;
        logic [31:0] dat;
        // byte lanes are accepted but every access is treated as a full word
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // register word indices
    localparam logic [1:0] REG_DATA   = 2'd0;
    localparam logic [1:0] REG_STATUS = 2'd1;
    localparam logic [1:0] REG_CTRL   = 2'd2;

    // status word bit positions
    localparam int ST_RX_EMPTY  = 0;
    localparam int ST_TX_FULL   = 1;
    localparam int ST_TX_IDLE   = 2;
    localparam int ST_OVERRUN   = 3;
    localparam int ST_FRAME_ERR = 4;

    // control word bit positions
    localparam int CTRL_LOOPBACK = 0;

endpackage

// File: common/uart_pkg.sv
package uart_pkg;

    // system clock and serial line rate
    localparam int CLK_FREQ_HZ = 12_000_000;
    localparam int BAUD_RATE   = 1_500_000;

    // the core advances once its counter passes this value,
    // so one bit on the line lasts BIT_DIVIDER + 2 clocks
    localparam int BIT_DIVIDER = CLK_FREQ_HZ / BAUD_RATE;
    localparam int DIV_W       = $clog2(BIT_DIVIDER + 2);

    // transmitter frame and the idle preamble sent after reset
    localparam logic [3:0] TX_FRAME_BITS = 4'd10;
    localparam logic [3:0] TX_IDLE_BITS  = 4'd15;

    // receiver states; every state between first bit and stop takes one data sample
    localparam logic [3:0] RX_IDLE      = 4'd0;
    localparam logic [3:0] RX_START     = 4'd1;
    localparam logic [3:0] RX_FIRST_BIT = 4'd2;
    localparam logic [3:0] RX_STOP      = 4'd10;

    // both FIFOs share one depth
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // one received character, frame_err lands in bit 8 of a DATA read
    typedef struct packed {
        logic       frame_err;
        logic [7:0] data;
    } rx_entry_t;

endpackage
